/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= fp_arith_unit_tb
FILELIST ?= fp_arith_unit.f
BUILD_DIR ?= obj_dir

SOURCES := $(wildcard hw/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* fp_arith_unit.f */
+incdir+tb
hw/fp_arith_pkg.sv
hw/lane_pipe_if.sv
hw/fp_unpack_stage.sv
hw/fp_add_path.sv
hw/fp_mul_path.sv
hw/fp_result_select.sv
hw/fp_arith_unit.sv
tb/fp_arith_unit_tb.sv

/* hw/fp_add_path.sv */
`default_nettype none

module fp_add_path
	import fp_arith_pkg::*;
#(
	parameter int num_lanes = num_lanes_default
)
(
	input logic clk,
	input logic reset,
	lane_pipe_if.sink add_ch,
	output logic sum_valid,
	output thread_idx_t sum_thread,
	output logic [num_lanes-1:0] sum_mask,
	output binary32_t [num_lanes-1:0] sum_result,
	output logic [num_lanes-1:0] sum_is_inf,
	output logic [num_lanes-1:0] sum_is_nan
);

	binary32_t [num_lanes-1:0] lane_result;
	logic [num_lanes-1:0] lane_inf;
	logic [num_lanes-1:0] lane_nan;

	// Zeros above the leading one or 27 when the value is all zero
	function automatic logic [4:0] count_leading_zeros(input logic [26:0] value);
		logic [4:0] count;
		logic found;
		count = 5'd0;
		found = 1'b0;
		for (int i = 26; i >= 0; i--)
		begin
			if (!found)
			begin
				if (value[i])
					found = 1'b1;
				else
					count = count + 5'd1;
			end
		end
		return count;
	endfunction

	for (genvar lane = 0; lane < num_lanes; lane++)
	begin : g_lane
		add_operands_t op;
		logic [26:0] le_ext;
		logic [26:0] se_ext;
		logic [27:0] raw_sum;
		logic carry;
		logic [4:0] lead_zeros;
		logic [26:0] norm_shifted;
		logic [23:0] norm_sig;
		logic signed [9:0] norm_exp;
		binary32_t result;

		assign op = add_ch.payload[lane];

		// Three guard bits below the significand are dropped when packing
		assign le_ext = {op.significand_le, 3'b000};
		assign se_ext = {op.significand_se, 3'b000} >> op.align_shift;

		// Larger magnitude is first so the difference never goes negative
		assign raw_sum = op.logical_subtract ? {1'b0, le_ext} - {1'b0, se_ext}
			: {1'b0, le_ext} + {1'b0, se_ext};

		assign carry = raw_sum[27];
		assign lead_zeros = count_leading_zeros(raw_sum[26:0]);
		assign norm_shifted = raw_sum[26:0] << lead_zeros;

		// Carry needs one right shift and otherwise a left shift to the leading one
		assign norm_sig = carry ? raw_sum[27:4] : norm_shifted[26:3];
		assign norm_exp = carry ? $signed({2'b00, op.exponent}) + 10'sd1
			: $signed({2'b00, op.exponent}) - $signed({5'd0, lead_zeros});

		always_comb
		begin
			if (raw_sum == 28'd0)
				// Exact cancellation is +0 while two negative zeros stay -0
				result = {op.result_sign && !op.logical_subtract, 31'd0};
			else if (norm_exp <= 10'sd0)
				result = {op.result_sign, 31'd0};
			else if (norm_exp >= 10'sd255)
				result = {op.result_sign, 8'hff, 23'd0};
			else
				result = {op.result_sign, norm_exp[7:0], norm_sig[22:0]};
		end

		assign lane_result[lane] = result;
		assign lane_inf[lane] = op.is_inf;
		assign lane_nan[lane] = op.is_nan;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sum_valid <= 1'b0;
			sum_thread <= '0;
			sum_mask <= '0;
		end
		else
		begin
			sum_valid <= add_ch.valid;
			sum_thread <= add_ch.thread;
			sum_mask <= add_ch.mask;
		end
	end

	always_ff @(posedge clk)
	begin
		sum_result <= lane_result;
		sum_is_inf <= lane_inf;
		sum_is_nan <= lane_nan;
	end

endmodule

`default_nettype wire

/* hw/fp_arith_pkg.sv */
`default_nettype none

package fp_arith_pkg;

	// Lane count used unless the top level overrides it
	localparam int num_lanes_default = 4;

	typedef logic [1:0] thread_idx_t;

	// Operations handled by this unit
	typedef enum logic [1:0]
	{
		op_fadd = 2'd0,
		op_fsub = 2'd1,
		op_fmul = 2'd2
	} fp_op_t;

	// IEEE 754 single precision layout
	typedef struct packed
	{
		logic sign;
		logic [7:0] exponent;
		logic [22:0] significand;
	} binary32_t;

	// Add path operands, already swapped and aligned
	typedef struct packed
	{
		logic [23:0] significand_le;
		logic [23:0] significand_se;
		logic [4:0] align_shift;
		logic [7:0] exponent;
		logic logical_subtract;
		logic result_sign;
		logic is_inf;
		logic is_nan;
	} add_operands_t;

	// Multiply path operands
	typedef struct packed
	{
		logic [47:0] product;
		// Biased result exponent that may fall out of range
		logic signed [9:0] exponent_sum;
		logic sign;
		logic is_inf;
		logic is_nan;
	} mul_operands_t;

	// Single canonical NaN for every invalid result
	localparam logic [31:0] quiet_nan = 32'h7fc00000;

endpackage

`default_nettype wire

/* hw/fp_arith_unit.sv */
`default_nettype none

module fp_arith_unit
	import fp_arith_pkg::*;
#(
	parameter int num_lanes = num_lanes_default
)
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input fp_op_t in_op,
	input thread_idx_t in_thread,
	input logic [num_lanes-1:0] in_mask,
	// Lane 0 in the low 32 bits
	input logic [num_lanes*32-1:0] in_operand1,
	input logic [num_lanes*32-1:0] in_operand2,
	input logic rollback_en,
	input thread_idx_t rollback_thread,
	output logic out_valid,
	output thread_idx_t out_thread,
	output logic [num_lanes-1:0] out_mask,
	output logic [num_lanes*32-1:0] out_result
);

	logic sum_valid;
	thread_idx_t sum_thread;
	logic [num_lanes-1:0] sum_mask;
	binary32_t [num_lanes-1:0] sum_result;
	logic [num_lanes-1:0] sum_is_inf;
	logic [num_lanes-1:0] sum_is_nan;
	logic prod_valid;
	thread_idx_t prod_thread;
	logic [num_lanes-1:0] prod_mask;
	binary32_t [num_lanes-1:0] prod_result;
	logic [num_lanes-1:0] prod_is_inf;
	logic [num_lanes-1:0] prod_is_nan;

	// Stage one to the two paths
	lane_pipe_if #(.payload_t(add_operands_t), .num_lanes(num_lanes)) add_ch ();
	lane_pipe_if #(.payload_t(mul_operands_t), .num_lanes(num_lanes)) mul_ch ();

	fp_unpack_stage #(.num_lanes(num_lanes)) u_unpack (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_thread(in_thread),
		.in_mask(in_mask),
		.in_operand1(in_operand1),
		.in_operand2(in_operand2),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.add_ch(add_ch.source),
		.mul_ch(mul_ch.source)
	);

	fp_add_path #(.num_lanes(num_lanes)) u_add (
		.clk(clk),
		.reset(reset),
		.add_ch(add_ch.sink),
		.sum_valid(sum_valid),
		.sum_thread(sum_thread),
		.sum_mask(sum_mask),
		.sum_result(sum_result),
		.sum_is_inf(sum_is_inf),
		.sum_is_nan(sum_is_nan)
	);

	fp_mul_path #(.num_lanes(num_lanes)) u_mul (
		.clk(clk),
		.reset(reset),
		.mul_ch(mul_ch.sink),
		.prod_valid(prod_valid),
		.prod_thread(prod_thread),
		.prod_mask(prod_mask),
		.prod_result(prod_result),
		.prod_is_inf(prod_is_inf),
		.prod_is_nan(prod_is_nan)
	);

	fp_result_select #(.num_lanes(num_lanes)) u_select (
		.clk(clk),
		.reset(reset),
		.sum_valid(sum_valid),
		.sum_thread(sum_thread),
		.sum_mask(sum_mask),
		.sum_result(sum_result),
		.sum_is_inf(sum_is_inf),
		.sum_is_nan(sum_is_nan),
		.prod_valid(prod_valid),
		.prod_thread(prod_thread),
		.prod_mask(prod_mask),
		.prod_result(prod_result),
		.prod_is_inf(prod_is_inf),
		.prod_is_nan(prod_is_nan),
		.out_valid(out_valid),
		.out_thread(out_thread),
		.out_mask(out_mask),
		.out_result(out_result)
	);

endmodule

`default_nettype wire

/* hw/fp_mul_path.sv */
`default_nettype none

module fp_mul_path
	import fp_arith_pkg::*;
#(
	parameter int num_lanes = num_lanes_default
)
(
	input logic clk,
	input logic reset,
	lane_pipe_if.sink mul_ch,
	output logic prod_valid,
	output thread_idx_t prod_thread,
	output logic [num_lanes-1:0] prod_mask,
	output binary32_t [num_lanes-1:0] prod_result,
	output logic [num_lanes-1:0] prod_is_inf,
	output logic [num_lanes-1:0] prod_is_nan
);

	binary32_t [num_lanes-1:0] lane_result;
	logic [num_lanes-1:0] lane_inf;
	logic [num_lanes-1:0] lane_nan;

	for (genvar lane = 0; lane < num_lanes; lane++)
	begin : g_lane
		mul_operands_t op;
		logic [23:0] norm_sig;
		logic signed [9:0] norm_exp;
		binary32_t result;

		assign op = mul_ch.payload[lane];

		// Product of two normals lies in [1, 4)
		assign norm_sig = op.product[47] ? op.product[47:24] : op.product[46:23];
		assign norm_exp = op.exponent_sum + $signed({9'd0, op.product[47]});

		always_comb
		begin
			// Zero operand, subnormal input or underflow all give signed zero
			if (op.product[47:46] == 2'b00 || norm_exp <= 10'sd0)
				result = {op.sign, 31'd0};
			else if (norm_exp >= 10'sd255)
				result = {op.sign, 8'hff, 23'd0};
			else
				result = {op.sign, norm_exp[7:0], norm_sig[22:0]};
		end

		assign lane_result[lane] = result;
		assign lane_inf[lane] = op.is_inf;
		assign lane_nan[lane] = op.is_nan;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			prod_valid <= 1'b0;
			prod_thread <= '0;
			prod_mask <= '0;
		end
		else
		begin
			prod_valid <= mul_ch.valid;
			prod_thread <= mul_ch.thread;
			prod_mask <= mul_ch.mask;
		end
	end

	always_ff @(posedge clk)
	begin
		prod_result <= lane_result;
		prod_is_inf <= lane_inf;
		prod_is_nan <= lane_nan;
	end

endmodule

`default_nettype wire

/* hw/fp_result_select.sv */
`default_nettype none

module fp_result_select
	import fp_arith_pkg::*;
#(
	parameter int num_lanes = num_lanes_default
)
(
	input logic clk,
	input logic reset,
	input logic sum_valid,
	input thread_idx_t sum_thread,
	input logic [num_lanes-1:0] sum_mask,
	input binary32_t [num_lanes-1:0] sum_result,
	input logic [num_lanes-1:0] sum_is_inf,
	input logic [num_lanes-1:0] sum_is_nan,
	input logic prod_valid,
	input thread_idx_t prod_thread,
	input logic [num_lanes-1:0] prod_mask,
	input binary32_t [num_lanes-1:0] prod_result,
	input logic [num_lanes-1:0] prod_is_inf,
	input logic [num_lanes-1:0] prod_is_nan,
	output logic out_valid,
	output thread_idx_t out_thread,
	output logic [num_lanes-1:0] out_mask,
	output binary32_t [num_lanes-1:0] out_result
);

	binary32_t [num_lanes-1:0] lane_result;

	for (genvar lane = 0; lane < num_lanes; lane++)
	begin : g_lane
		binary32_t path_result;
		logic is_inf;
		logic is_nan;

		// At most one path is valid in a cycle
		assign path_result = sum_valid ? sum_result[lane] : prod_result[lane];
		assign is_inf = sum_valid ? sum_is_inf[lane] : prod_is_inf[lane];
		assign is_nan = sum_valid ? sum_is_nan[lane] : prod_is_nan[lane];

		// NaN wins over infinity
		always_comb
		begin
			if (is_nan)
				lane_result[lane] = quiet_nan;
			else if (is_inf)
				lane_result[lane] = {path_result.sign, 8'hff, 23'd0};
			else
				lane_result[lane] = path_result;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			out_thread <= '0;
			out_mask <= '0;
		end
		else
		begin
			out_valid <= sum_valid || prod_valid;
			out_thread <= sum_valid ? sum_thread : prod_thread;
			out_mask <= sum_valid ? sum_mask : prod_mask;
		end
	end

	always_ff @(posedge clk)
		out_result <= lane_result;

endmodule

`default_nettype wire

/* hw/fp_unpack_stage.sv */
`default_nettype none

module fp_unpack_stage
	import fp_arith_pkg::*;
#(
	parameter int num_lanes = num_lanes_default
)
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input fp_op_t in_op,
	input thread_idx_t in_thread,
	input logic [num_lanes-1:0] in_mask,
	input binary32_t [num_lanes-1:0] in_operand1,
	input binary32_t [num_lanes-1:0] in_operand2,
	input logic rollback_en,
	input thread_idx_t rollback_thread,
	lane_pipe_if.source add_ch,
	lane_pipe_if.source mul_ch
);

	logic issue_ok;
	logic is_subtract;
	add_operands_t add_next [num_lanes];
	mul_operands_t mul_next [num_lanes];

	// Drop issues from a thread that is rolling back this cycle
	assign issue_ok = in_valid && !(rollback_en && rollback_thread == in_thread);
	assign is_subtract = in_op == op_fsub;

	for (genvar lane = 0; lane < num_lanes; lane++)
	begin : g_lane
		binary32_t op1;
		binary32_t op2;
		logic [23:0] sig1;
		logic [23:0] sig2;
		logic op1_inf;
		logic op1_nan;
		logic op1_zero;
		logic op2_inf;
		logic op2_nan;
		logic op2_zero;
		logic logical_subtract;
		logic op1_larger;
		logic [7:0] exp_diff;
		add_operands_t add_lane;
		mul_operands_t mul_lane;

		assign op1 = in_operand1[lane];
		assign op2 = in_operand2[lane];

		// Hidden bit is absent for zero and subnormal
		assign sig1 = {op1.exponent != 8'd0, op1.significand};
		assign sig2 = {op2.exponent != 8'd0, op2.significand};

		assign op1_inf = op1.exponent == 8'hff && op1.significand == 23'd0;
		assign op1_nan = op1.exponent == 8'hff && op1.significand != 23'd0;
		assign op1_zero = op1.exponent == 8'd0 && op1.significand == 23'd0;
		assign op2_inf = op2.exponent == 8'hff && op2.significand == 23'd0;
		assign op2_nan = op2.exponent == 8'hff && op2.significand != 23'd0;
		assign op2_zero = op2.exponent == 8'd0 && op2.significand == 23'd0;

		// Signs differ after the subtract flips operand2
		assign logical_subtract = op1.sign ^ op2.sign ^ is_subtract;

		// Ties keep operand1 first so zero signs come out right
		assign op1_larger = op1.exponent > op2.exponent
			|| (op1.exponent == op2.exponent && sig1 >= sig2);
		assign exp_diff = op1_larger ? op1.exponent - op2.exponent
			: op2.exponent - op1.exponent;

		always_comb
		begin
			if (op1_larger)
			begin
				add_lane.significand_le = sig1;
				add_lane.significand_se = sig2;
				add_lane.exponent = op1.exponent;
				add_lane.result_sign = op1.sign;
			end
			else
			begin
				add_lane.significand_le = sig2;
				add_lane.significand_se = sig1;
				add_lane.exponent = op2.exponent;
				add_lane.result_sign = op2.sign ^ is_subtract;
			end
			// A shift of 27 clears the significand and all three guard bits
			add_lane.align_shift = exp_diff > 8'd27 ? 5'd27 : exp_diff[4:0];
			add_lane.logical_subtract = logical_subtract;
			// Opposite infinities cancel into NaN
			add_lane.is_nan = op1_nan || op2_nan || (op1_inf && op2_inf && logical_subtract);
			add_lane.is_inf = !add_lane.is_nan && (op1_inf || op2_inf);
		end

		always_comb
		begin
			mul_lane.product = {24'd0, sig1} * {24'd0, sig2};
			// Sum of biased exponents less one bias of 127
			mul_lane.exponent_sum = $signed({2'b00, op1.exponent} + {2'b00, op2.exponent}
				- 10'd127);
			mul_lane.sign = op1.sign ^ op2.sign;
			mul_lane.is_nan = op1_nan || op2_nan || (op1_inf && op2_zero)
				|| (op2_inf && op1_zero);
			mul_lane.is_inf = !mul_lane.is_nan && (op1_inf || op2_inf);
		end

		assign add_next[lane] = add_lane;
		assign mul_next[lane] = mul_lane;
	end

	// Control state
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			add_ch.valid <= 1'b0;
			add_ch.thread <= '0;
			add_ch.mask <= '0;
			mul_ch.valid <= 1'b0;
			mul_ch.thread <= '0;
			mul_ch.mask <= '0;
		end
		else
		begin
			// Only one channel carries a given issue
			add_ch.valid <= issue_ok && in_op != op_fmul;
			add_ch.thread <= in_thread;
			add_ch.mask <= in_mask;
			mul_ch.valid <= issue_ok && in_op == op_fmul;
			mul_ch.thread <= in_thread;
			mul_ch.mask <= in_mask;
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		add_ch.payload <= add_next;
		mul_ch.payload <= mul_next;
	end

endmodule

`default_nettype wire

/* hw/lane_pipe_if.sv */
`default_nettype none

interface lane_pipe_if
	import fp_arith_pkg::*;
#(
	parameter type payload_t = logic,
	parameter int num_lanes = num_lanes_default
)
();

	// Valid only with no back-pressure
	logic valid;
	thread_idx_t thread;
	logic [num_lanes-1:0] mask;
	// One payload per vector lane
	payload_t payload [num_lanes];

	modport source (output valid, output thread, output mask, output payload);
	modport sink (input valid, input thread, input mask, input payload);

endinterface

`default_nettype wire

/* tb/fp_arith_vectors.svh */
`ifndef FP_ARITH_VECTORS_SVH
`define FP_ARITH_VECTORS_SVH

// Columns are op, thread, mask, rollback_en, rollback_thread, expect_out,
// then operand1, operand2 and expected result with lanes listed 3 down to 0
typedef struct packed
{
	fp_op_t op;
	thread_idx_t thread;
	logic [lanes-1:0] mask;
	logic rollback_en;
	thread_idx_t rollback_thread;
	logic expect_out;
	logic [lanes*32-1:0] operand1;
	logic [lanes*32-1:0] operand2;
	logic [lanes*32-1:0] expected;
} vector_row_t;

localparam int num_rows = 13;

localparam vector_row_t vectors [num_rows] = '{
	// -0 + -0, 1.5 + -1.5, 1.0 + 1.0 with carry, 1.5 + 2.25
	'{op_fadd, 2'd0, 4'hf, 1'b0, 2'd0, 1'b1,
		{32'h80000000, 32'h3fc00000, 32'h3f800000, 32'h3fc00000},
		{32'h80000000, 32'hbfc00000, 32'h3f800000, 32'h40100000},
		{32'h80000000, 32'h00000000, 32'h40000000, 32'h40700000}},
	// 3.75 - 2.25, 2.0 - 0.5, 1.5 - 1.5, 1.0 - 3.0 with swap
	'{op_fsub, 2'd1, 4'h5, 1'b0, 2'd0, 1'b1,
		{32'h40700000, 32'h40000000, 32'h3fc00000, 32'h3f800000},
		{32'h40100000, 32'h3f000000, 32'h3fc00000, 32'h40400000},
		{32'h3fc00000, 32'h3fc00000, 32'h00000000, 32'hc0000000}},
	// Tiny times tiny flushes, 1.5 x 1.5 sets product bit 47
	'{op_fmul, 2'd2, 4'h3, 1'b0, 2'd0, 1'b1,
		{32'h8d800000, 32'h3fc00000, 32'hbf000000, 32'h3fc00000},
		{32'h0d800000, 32'h3fc00000, 32'h40800000, 32'h40000000},
		{32'h80000000, 32'h40100000, 32'hc0000000, 32'h40400000}},
	// 0 + 0, NaN + 1, 1 + -inf, inf + 1
	'{op_fadd, 2'd3, 4'hf, 1'b0, 2'd0, 1'b1,
		{32'h00000000, 32'h7f800001, 32'h3f800000, 32'h7f800000},
		{32'h00000000, 32'h3f800000, 32'hff800000, 32'h3f800000},
		{32'h00000000, 32'h7fc00000, 32'hff800000, 32'h7f800000}},
	// 2.25 - 1.5, 1 - NaN, -inf - 1, inf - inf
	'{op_fsub, 2'd0, 4'h8, 1'b0, 2'd0, 1'b1,
		{32'h40100000, 32'h3f800000, 32'hff800000, 32'h7f800000},
		{32'h3fc00000, 32'hffc00000, 32'h3f800000, 32'h7f800000},
		{32'h3f400000, 32'h7fc00000, 32'hff800000, 32'h7fc00000}},
	// -inf x 2, 2^100 x 2^100 overflows, 0 x -inf, inf x 0
	'{op_fmul, 2'd1, 4'hf, 1'b0, 2'd0, 1'b1,
		{32'hff800000, 32'h71800000, 32'h00000000, 32'h7f800000},
		{32'h40000000, 32'h71800000, 32'hff800000, 32'h00000000},
		{32'hff800000, 32'h7f800000, 32'h7fc00000, 32'h7fc00000}},
	// Squashed by a rollback on its own thread
	'{op_fadd, 2'd2, 4'hf, 1'b1, 2'd2, 1'b0,
		{4{32'h3f800000}}, {4{32'h3f800000}}, '0},
	// Rollback of another thread leaves this one alone
	'{op_fmul, 2'd3, 4'h9, 1'b1, 2'd0, 1'b1,
		{32'h3f000000, 32'hbf800000, 32'h00000000, 32'h40000000},
		{32'h80000000, 32'hbf800000, 32'h40400000, 32'h40000000},
		{32'h80000000, 32'h3f800000, 32'h00000000, 32'h40800000}},
	// Squashed multiply
	'{op_fmul, 2'd1, 4'h2, 1'b1, 2'd1, 1'b0,
		{4{32'h40000000}}, {4{32'h40000000}}, '0},
	// 4 + -1, -1.5 + -2.25, 0.5 + 0.5, 1 + 2
	'{op_fadd, 2'd0, 4'h1, 1'b0, 2'd0, 1'b1,
		{32'h40800000, 32'hbfc00000, 32'h3f000000, 32'h3f800000},
		{32'hbf800000, 32'hc0100000, 32'h3f000000, 32'h40000000},
		{32'h40400000, 32'hc0700000, 32'h3f800000, 32'h40400000}},
	// Tiny x tiny, 4 x 4, -1.5 x -1.5, 3 x 0.5
	'{op_fmul, 2'd2, 4'h6, 1'b0, 2'd0, 1'b1,
		{32'h0d800000, 32'h40800000, 32'hbfc00000, 32'h40400000},
		{32'h0d800000, 32'h40800000, 32'hbfc00000, 32'h3f000000},
		{32'h00000000, 32'h41800000, 32'h40100000, 32'h3fc00000}},
	// 1 - -1, 0.5 - 2, -2 - -2, 3.75 - 3.75
	'{op_fsub, 2'd3, 4'ha, 1'b0, 2'd0, 1'b1,
		{32'h3f800000, 32'h3f000000, 32'hc0000000, 32'h40700000},
		{32'hbf800000, 32'h40000000, 32'hc0000000, 32'h40700000},
		{32'h40000000, 32'hbfc00000, 32'h00000000, 32'h00000000}},
	// -3 x 1, 2^100 x -2^100, 2.25 x 2, 1 x 1
	'{op_fmul, 2'd0, 4'hc, 1'b0, 2'd0, 1'b1,
		{32'hc0400000, 32'h71800000, 32'h40100000, 32'h3f800000},
		{32'h3f800000, 32'hf1800000, 32'h40000000, 32'h3f800000},
		{32'hc0400000, 32'hff800000, 32'h40900000, 32'h3f800000}}
};

`endif

/* tb/fp_arith_unit_tb.sv */
`default_nettype none

module fp_arith_unit_tb
	import fp_arith_pkg::*;
();

	localparam int lanes = 4;
	localparam int clk_period = 10;
	// Issue to out_valid
	localparam int latency = 3;

`include "fp_arith_vectors.svh"

	logic clk;
	logic reset;
	logic in_valid;
	fp_op_t in_op;
	thread_idx_t in_thread;
	logic [lanes-1:0] in_mask;
	logic [lanes*32-1:0] in_operand1;
	logic [lanes*32-1:0] in_operand2;
	logic rollback_en;
	thread_idx_t rollback_thread;
	logic out_valid;
	thread_idx_t out_thread;
	logic [lanes-1:0] out_mask;
	logic [lanes*32-1:0] out_result;

	// Rows still owed a result, and the cycle each one is due
	int pending_rows [$];
	int pending_due [$];
	int cycle_count = 0;

	fp_arith_unit #(.num_lanes(lanes)) u_dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_thread(in_thread),
		.in_mask(in_mask),
		.in_operand1(in_operand1),
		.in_operand2(in_operand2),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.out_valid(out_valid),
		.out_thread(out_thread),
		.out_mask(out_mask),
		.out_result(out_result)
	);

	always #(clk_period / 2) clk = ~clk;

	// Counts rising edges
	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stop_on_error($sformatf("mismatch at time %0t: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	// Scoreboard sampled away from the rising edge
	always @(negedge clk)
	begin
		int row;
		int due;
		if (reset)
			compare("out_valid", 32'(out_valid), 32'd0);
		else if (out_valid)
		begin
			if (pending_rows.size() == 0)
				stop_on_error("out_valid went high with no issue waiting for a result");
			else
			begin
				row = pending_rows.pop_front();
				due = pending_due.pop_front();
				compare("out_valid cycle", cycle_count, due);
				compare("out_thread", 32'(out_thread), 32'(vectors[row].thread));
				compare("out_mask", 32'(out_mask), 32'(vectors[row].mask));
				for (int lane = 0; lane < lanes; lane++)
					compare($sformatf("out_result[%0d]", lane), out_result[lane*32 +: 32],
						vectors[row].expected[lane*32 +: 32]);
			end
		end
		else if (pending_due.size() != 0 && cycle_count > pending_due[0])
			stop_on_error($sformatf("no result arrived for vector row %0d", pending_rows[0]));
	end

	// Limit on the whole run once reset is released
	initial
	begin
		@(negedge reset);
		#((num_rows + 10) * clk_period);
		stop_on_error("timeout, results still outstanding when the watchdog expired");
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = op_fadd;
		in_thread = '0;
		in_mask = '0;
		in_operand1 = '0;
		in_operand2 = '0;
		rollback_en = 1'b0;
		rollback_thread = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// One issue per cycle with no gaps
		for (int i = 0; i < num_rows; i++)
		begin
			in_valid = 1'b1;
			in_op = vectors[i].op;
			in_thread = vectors[i].thread;
			in_mask = vectors[i].mask;
			in_operand1 = vectors[i].operand1;
			in_operand2 = vectors[i].operand2;
			rollback_en = vectors[i].rollback_en;
			rollback_thread = vectors[i].rollback_thread;
			if (vectors[i].expect_out)
			begin
				pending_rows.push_back(i);
				pending_due.push_back(cycle_count + latency);
			end
			@(negedge clk);
		end
		in_valid = 1'b0;
		rollback_en = 1'b0;
		while (pending_rows.size() != 0)
			@(negedge clk);
		// Idle cycles to catch a stray output from a squashed row
		repeat (4) @(negedge clk);
		if (pending_rows.size() == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
			stop_on_error("rows still waiting for a result at the end of the run");
	end

endmodule

`default_nettype wire
